// File: bench/tdr_retry_tb.sv
`timescale 1ns/10ps
`default_nettype none

module tdr_retry_tb;

    localparam int unsigned random_seed = 51659;
    localparam int unsigned num_clean_items = 300;
    localparam int unsigned num_fault_items = 100;
    localparam int unsigned num_fault_pulses = 20;
    localparam int unsigned timeout_cycles = 40 * (num_clean_items + num_fault_items) + 200;
    localparam int unsigned key_width = $bits(tdr_pkg::op_t) + $bits(tdr_pkg::data_t);

    logic           clk_i;
    logic           rst_i;
    tdr_pkg::op_t   operation_i;
    tdr_pkg::data_t data_i;
    logic           valid_i;
    logic           ready_o;
    tdr_pkg::data_t fault_data_i;
    tdr_pkg::op_t   operation_o;
    tdr_pkg::data_t data_o;
    logic           valid_o;
    logic           ready_i;

    // Outstanding items by operation and data
    int sb_count [logic [key_width-1:0]];
    int sent_per_op [tdr_pkg::num_opgroups];
    int delivered_per_op [tdr_pkg::num_opgroups];
    int sent_total = 0;
    int delivered_total = 0;
    int out_count = 0;
    int value_errors = 0;
    int other_errors = 0;
    int cycle_count = 0;
    logic input_seen = 1'b0;

    // Output values seen in the last two cycles
    tdr_pkg::op_t   cur_op, prev_op;
    tdr_pkg::data_t cur_data, prev_data;

    tdr_retry_top #(
        .lock_timeout(5)
    ) dut0 (
        .clk_i(clk_i), .rst_i(rst_i),
        .operation_i(operation_i), .data_i(data_i), .valid_i(valid_i), .ready_o(ready_o),
        .fault_data_i(fault_data_i),
        .operation_o(operation_o), .data_o(data_o), .valid_o(valid_o), .ready_i(ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic report_mismatch(input string name, input int expected, input int got);
        value_errors++;
        $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, got);
    endtask

    // Transfers are counted half a cycle ahead of the edge that completes them
    always @(negedge clk_i) begin
        logic [key_width-1:0] key;
        prev_op <= cur_op;
        prev_data <= cur_data;
        cur_op <= operation_o;
        cur_data <= data_o;
        if (!rst_i) begin
            if (valid_i && ready_o) begin
                key = {operation_i, data_i};
                if (sb_count.exists(key)) begin
                    sb_count[key]++;
                end else begin
                    sb_count[key] = 1;
                end
                sent_per_op[operation_i]++;
                sent_total++;
                input_seen <= 1'b1;
            end
            if (valid_o && ready_i) begin
                key = {operation_o, data_o};
                out_count = sb_count.exists(key) ? sb_count[key] : 0;
                if (out_count > 0) begin
                    sb_count[key]--;
                end
                delivered_per_op[operation_o]++;
                delivered_total++;
            end
        end
    end

    a_idle_before_input: assert property (
        @(posedge clk_i) disable iff (rst_i) !input_seen |-> !valid_o
    ) else report_mismatch("valid_o", 0, 1);

    // An accepted item blocks the input while its two copies go out
    a_ready_after_accept: assert property (
        @(posedge clk_i) disable iff (rst_i) valid_i && ready_o |=> !ready_o ##1 !ready_o
    ) else report_mismatch("ready_o", 0, 1);

    // Every delivered item must still be outstanding
    a_output_known: assert property (
        @(posedge clk_i) disable iff (rst_i) valid_o && ready_i |-> out_count > 0
    ) else begin
        value_errors++;
        $display("mismatch at %0t: count of operation_o=%0d data_o=%h expected >0 got %0d",
            $time, cur_op, cur_data, out_count);
    end

    a_valid_held: assert property (
        @(posedge clk_i) disable iff (rst_i) valid_o && !ready_i |=> valid_o
    ) else report_mismatch("valid_o", 1, 0);

    a_op_held: assert property (
        @(posedge clk_i) disable iff (rst_i) valid_o && !ready_i |=> $stable(operation_o)
    ) else report_mismatch("operation_o", prev_op, cur_op);

    a_data_held: assert property (
        @(posedge clk_i) disable iff (rst_i) valid_o && !ready_i |=> $stable(data_o)
    ) else report_mismatch("data_o", prev_data, cur_data);

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout at cycle %0d: %0d undelivered, %0d mismatches, %0d other errors",
                cycle_count, sent_total - delivered_total, value_errors, other_errors);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Starts on a rising edge and returns on the edge of the transfer
    task automatic send_item(input tdr_pkg::op_t op, input tdr_pkg::data_t data);
        operation_i <= op;
        data_i <= data;
        valid_i <= 1'b1;
        @(negedge clk_i);
        while (!ready_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        valid_i <= 1'b0;
    endtask

    task automatic send_items(input int unsigned count);
        int unsigned gap;
        for (int unsigned i = 0; i < count; i++) begin
            gap = ($urandom_range(3) == 0) ? $urandom_range(3, 1) : 0;
            repeat (gap) @(posedge clk_i);
            send_item(tdr_pkg::op_t'($urandom_range(tdr_pkg::num_opgroups - 1)),
                tdr_pkg::data_t'($urandom));
        end
    endtask

    task automatic inject_faults(input int unsigned count);
        repeat (count) begin
            repeat ($urandom_range(14, 6)) @(posedge clk_i);
            fault_data_i <= tdr_pkg::data_t'($urandom_range(16'hffff, 1));
            @(posedge clk_i);
            fault_data_i <= '0;
        end
    endtask

    task automatic drive_ready();
        forever begin
            @(posedge clk_i);
            ready_i <= ($urandom_range(3) != 0);
        end
    endtask

    task automatic drain_outputs();
        while (delivered_total != sent_total) begin
            @(posedge clk_i);
        end
        // Extra outputs would show up here as unknown items
        repeat (20) @(posedge clk_i);
    endtask

    task automatic check_balance();
        foreach (sb_count[key]) begin
            assert (sb_count[key] == 0)
            else report_mismatch($sformatf("count of item %h", key), 0, sb_count[key]);
        end
        for (int op = 0; op < tdr_pkg::num_opgroups; op++) begin
            assert (delivered_per_op[op] == sent_per_op[op])
            else report_mismatch($sformatf("delivered[%0d]", op),
                sent_per_op[op], delivered_per_op[op]);
        end
        assert (!dut0.lock)
        else begin
            other_errors++;
            $display("Lock is still held at %0t after all items were delivered", $time);
        end
    endtask

    initial begin
        void'($urandom(random_seed));
        rst_i = 1'b1;
        operation_i = '0;
        data_i = '0;
        valid_i = 1'b0;
        fault_data_i = '0;
        ready_i = 1'b0;
        for (int op = 0; op < tdr_pkg::num_opgroups; op++) begin
            sent_per_op[op] = 0;
            delivered_per_op[op] = 0;
        end
        repeat (5) @(posedge clk_i);
        rst_i <= 1'b0;
        fork
            drive_ready();
        join_none
        repeat (3) @(posedge clk_i);

        // Clean traffic under random back-pressure
        send_items(num_clean_items);
        drain_outputs();
        check_balance();

        // Traffic with corrupted copies that must be retried
        fork
            send_items(num_fault_items);
            inject_faults(num_fault_pulses);
        join
        drain_outputs();
        check_balance();

        $display("Checks done: %0d value mismatches, %0d other errors, %0d items delivered",
            value_errors, other_errors, delivered_total);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hdl/tdr_pkg.sv
hdl/retry_start.sv
hdl/time_dmr_start.sv
hdl/opgroup_pipe.sv
hdl/rr_arb_lock.sv
hdl/time_dmr_end.sv
hdl/retry_end.sv
hdl/tdr_retry_top.sv
bench/tdr_retry_tb.sv

// File: hdl/opgroup_pipe.sv
`timescale 1ns/10ps
`default_nettype none

module opgroup_pipe #(
    parameter int unsigned depth = 2
) (
    input  logic           clk_i,
    input  logic           rst_i,
    input  tdr_pkg::data_t data_i,
    input  tdr_pkg::id_t   id_i,
    input  logic           valid_i,
    output logic           ready_o,
    output tdr_pkg::data_t data_o,
    output tdr_pkg::id_t   id_o,
    output logic           valid_o,
    input  logic           ready_i
);

    // Index i holds the item after i stages
    tdr_pkg::data_t pipe_data  [0:depth];
    tdr_pkg::id_t   pipe_id    [0:depth];
    logic           pipe_valid [0:depth];
    logic           pipe_ready [0:depth];

    assign pipe_data[0] = data_i;
    assign pipe_id[0] = id_i;
    assign pipe_valid[0] = valid_i;
    assign ready_o = pipe_ready[0];

    for (genvar i = 0; i < depth; i++) begin : gen_stage
        // Advance into a free stage or over a bubble
        assign pipe_ready[i] = pipe_ready[i+1] | ~pipe_valid[i+1];

        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                pipe_valid[i+1] <= 1'b0;
            end else if (pipe_ready[i]) begin
                pipe_valid[i+1] <= pipe_valid[i];
            end
        end

        always_ff @(posedge clk_i) begin
            if (pipe_ready[i] && pipe_valid[i]) begin
                pipe_data[i+1] <= pipe_data[i];
                pipe_id[i+1] <= pipe_id[i];
            end
        end
    end

    assign pipe_ready[depth] = ready_i;
    assign data_o = pipe_data[depth];
    assign id_o = pipe_id[depth];
    assign valid_o = pipe_valid[depth];

endmodule

`default_nettype wire

// File: hdl/retry_end.sv
`timescale 1ns/10ps
`default_nettype none

module retry_end (
    input  logic           clk_i,
    input  logic           rst_i,
    input  tdr_pkg::op_t   operation_i,
    input  tdr_pkg::data_t data_i,
    input  tdr_pkg::id_t   id_i,
    input  logic           faulty_i,
    input  logic           valid_i,
    output logic           ready_o,
    output tdr_pkg::op_t   operation_o,
    output tdr_pkg::data_t data_o,
    output logic           valid_o,
    input  logic           ready_i,
    output tdr_pkg::id_t   failed_id_o,
    output logic           failed_valid_o,
    input  logic           failed_ready_i
);

    // Good items leave, faulty ones go back by id
    assign operation_o = operation_i;
    assign data_o = data_i;
    assign valid_o = valid_i & ~faulty_i;

    assign failed_id_o = id_i;
    assign failed_valid_o = valid_i & faulty_i;

    assign ready_o = faulty_i ? failed_ready_i : ready_i;

    a_one_side_only: assert property (
        @(posedge clk_i) disable iff (rst_i) !(failed_valid_o && valid_o)
    );

endmodule

`default_nettype wire

// File: hdl/retry_start.sv
`timescale 1ns/10ps
`default_nettype none

module retry_start (
    input  logic           clk_i,
    input  logic           rst_i,
    input  tdr_pkg::op_t   operation_i,
    input  tdr_pkg::data_t data_i,
    input  logic           valid_i,
    output logic           ready_o,
    output tdr_pkg::op_t   operation_o,
    output tdr_pkg::data_t data_o,
    output tdr_pkg::id_t   id_o,
    output logic           valid_o,
    input  logic           ready_i,
    input  tdr_pkg::id_t   failed_id_i,
    input  logic           failed_valid_i,
    output logic           failed_ready_o
);

    // Copy of every issued item, indexed by id
    tdr_pkg::op_t   op_mem   [tdr_pkg::num_ids];
    tdr_pkg::data_t data_mem [tdr_pkg::num_ids];

    logic [tdr_pkg::num_ids-1:0] written_q;
    tdr_pkg::id_t                next_id_q;

    // One failed id waiting for re-issue
    logic         retry_valid_q;
    tdr_pkg::id_t retry_id_q;

    logic new_xfer;
    logic retry_xfer;
    logic failed_xfer;

    // Pending retry goes out ahead of new input
    assign operation_o = retry_valid_q ? op_mem[retry_id_q] : operation_i;
    assign data_o = retry_valid_q ? data_mem[retry_id_q] : data_i;
    assign id_o = retry_valid_q ? retry_id_q : next_id_q;
    assign valid_o = retry_valid_q | valid_i;
    assign ready_o = ready_i & ~retry_valid_q;

    // Slot frees up in the cycle its retry is taken
    assign failed_ready_o = ~retry_valid_q | ready_i;

    assign new_xfer = valid_i & ready_o;
    assign retry_xfer = retry_valid_q & ready_i;
    assign failed_xfer = failed_valid_i & failed_ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            next_id_q <= '0;
            written_q <= '0;
            retry_valid_q <= 1'b0;
        end else begin
            if (new_xfer) begin
                next_id_q <= next_id_q + 1'b1;
                written_q[next_id_q] <= 1'b1;
            end
            if (failed_xfer) begin
                retry_valid_q <= 1'b1;
            end else if (retry_xfer) begin
                retry_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (new_xfer) begin
            op_mem[next_id_q] <= operation_i;
            data_mem[next_id_q] <= data_i;
        end
        if (failed_xfer) begin
            retry_id_q <= failed_id_i;
        end
    end

    // Ids coming back from the exit were handed out here
    a_failed_id_known: assert property (
        @(posedge clk_i) disable iff (rst_i) failed_valid_i |-> written_q[failed_id_i]
    );

endmodule

`default_nettype wire

// File: hdl/rr_arb_lock.sv
`timescale 1ns/10ps
`default_nettype none

module rr_arb_lock (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             lock_i,
    input  logic [tdr_pkg::num_opgroups-1:0] valid_i,
    output logic [tdr_pkg::num_opgroups-1:0] ready_o,
    input  tdr_pkg::data_t                   data0_i,
    input  tdr_pkg::data_t                   data1_i,
    input  tdr_pkg::data_t                   data2_i,
    input  tdr_pkg::id_t                     id0_i,
    input  tdr_pkg::id_t                     id1_i,
    input  tdr_pkg::id_t                     id2_i,
    output logic                             valid_o,
    input  logic                             ready_i,
    output tdr_pkg::data_t                   data_o,
    output tdr_pkg::id_t                     id_o,
    output tdr_pkg::op_t                     operation_o
);

    tdr_pkg::data_t data_in [tdr_pkg::num_opgroups];
    tdr_pkg::id_t   id_in   [tdr_pkg::num_opgroups];

    // Highest priority index and the index granted last
    tdr_pkg::op_t ptr_q;
    tdr_pkg::op_t last_q;
    tdr_pkg::op_t sel;

    assign data_in[0] = data0_i;
    assign data_in[1] = data1_i;
    assign data_in[2] = data2_i;
    assign id_in[0] = id0_i;
    assign id_in[1] = id1_i;
    assign id_in[2] = id2_i;

    always_comb begin
        int unsigned idx;
        logic        found;
        sel = ptr_q;
        found = 1'b0;
        // First valid input at or after the pointer
        for (int unsigned k = 0; k < tdr_pkg::num_opgroups; k++) begin
            idx = (ptr_q + k) % tdr_pkg::num_opgroups;
            if (!found && valid_i[idx]) begin
                sel = tdr_pkg::op_t'(idx);
                found = 1'b1;
            end
        end
        // Locked grant stays with the last winner
        if (lock_i) begin
            sel = last_q;
        end
    end

    assign valid_o = valid_i[sel];
    assign data_o = data_in[sel];
    assign id_o = id_in[sel];
    assign operation_o = sel;

    always_comb begin
        ready_o = '0;
        ready_o[sel] = ready_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ptr_q <= '0;
            last_q <= '0;
        end else if (valid_o && ready_i) begin
            last_q <= sel;
            if (!lock_i) begin
                ptr_q <= (sel == tdr_pkg::op_t'(tdr_pkg::num_opgroups - 1)) ? '0 : sel + 1'b1;
            end
        end
    end

    a_ready_onehot: assert property (
        @(posedge clk_i) disable iff (rst_i) $onehot0(ready_o)
    );

endmodule

`default_nettype wire

// File: hdl/tdr_pkg.sv
`default_nettype none

package tdr_pkg;

    // Number of latency pipelines
    localparam int unsigned num_opgroups = 3;

    // Payload word
    typedef logic [15:0] data_t;

    // Opgroup code, one code per pipeline
    typedef logic [1:0] op_t;

    // Retry id, the id space must exceed the copies in flight
    typedef logic [4:0] id_t;

    // Entries in the retry table
    localparam int unsigned num_ids = 2 ** $bits(id_t);

endpackage

`default_nettype wire

// File: hdl/tdr_retry_top.sv
`timescale 1ns/10ps
`default_nettype none

module tdr_retry_top #(
    parameter int unsigned opgroup_depths [tdr_pkg::num_opgroups] = '{2, 3, 4},
    parameter int unsigned lock_timeout = 5
) (
    input  logic           clk_i,
    input  logic           rst_i,
    input  tdr_pkg::op_t   operation_i,
    input  tdr_pkg::data_t data_i,
    input  logic           valid_i,
    output logic           ready_o,
    input  tdr_pkg::data_t fault_data_i,
    output tdr_pkg::op_t   operation_o,
    output tdr_pkg::data_t data_o,
    output logic           valid_o,
    input  logic           ready_i
);

    // Retry start to DMR start
    tdr_pkg::op_t   rs_op;
    tdr_pkg::data_t rs_data;
    tdr_pkg::id_t   rs_id;
    logic           rs_valid, rs_ready;

    // DMR start to the pipes
    tdr_pkg::op_t   ds_op;
    tdr_pkg::data_t ds_data;
    tdr_pkg::id_t   ds_id;
    logic           ds_valid, ds_ready;

    tdr_pkg::data_t                   pipe_in_data;
    logic [tdr_pkg::num_opgroups-1:0] pipe_in_valid, pipe_in_ready;
    tdr_pkg::data_t                   po_data [tdr_pkg::num_opgroups];
    tdr_pkg::id_t                     po_id   [tdr_pkg::num_opgroups];
    logic [tdr_pkg::num_opgroups-1:0] po_valid, po_ready;

    // Arbiter to DMR end
    tdr_pkg::op_t   arb_op;
    tdr_pkg::data_t arb_data;
    tdr_pkg::id_t   arb_id;
    logic           arb_valid, arb_ready, lock;

    // DMR end to retry end, plus the retry link
    tdr_pkg::op_t   de_op;
    tdr_pkg::data_t de_data;
    tdr_pkg::id_t   de_id, failed_id;
    logic           de_faulty, de_valid, de_ready;
    logic           failed_valid, failed_ready;

    retry_start i_retry_start (
        .clk_i(clk_i), .rst_i(rst_i),
        .operation_i(operation_i), .data_i(data_i), .valid_i(valid_i), .ready_o(ready_o),
        .operation_o(rs_op), .data_o(rs_data), .id_o(rs_id),
        .valid_o(rs_valid), .ready_i(rs_ready),
        .failed_id_i(failed_id), .failed_valid_i(failed_valid), .failed_ready_o(failed_ready)
    );

    time_dmr_start i_time_dmr_start (
        .clk_i(clk_i), .rst_i(rst_i),
        .operation_i(rs_op), .data_i(rs_data), .id_i(rs_id),
        .valid_i(rs_valid), .ready_o(rs_ready),
        .operation_o(ds_op), .data_o(ds_data), .id_o(ds_id),
        .valid_o(ds_valid), .ready_i(ds_ready)
    );

    // Fault injection on the data entering the pipes
    assign pipe_in_data = ds_data ^ fault_data_i;
    assign ds_ready = pipe_in_ready[ds_op];

    for (genvar g = 0; g < tdr_pkg::num_opgroups; g++) begin : gen_opgroup
        assign pipe_in_valid[g] = ds_valid && (ds_op == tdr_pkg::op_t'(g));

        opgroup_pipe #(
            .depth(opgroup_depths[g])
        ) i_opgroup_pipe (
            .clk_i(clk_i), .rst_i(rst_i),
            .data_i(pipe_in_data), .id_i(ds_id),
            .valid_i(pipe_in_valid[g]), .ready_o(pipe_in_ready[g]),
            .data_o(po_data[g]), .id_o(po_id[g]),
            .valid_o(po_valid[g]), .ready_i(po_ready[g])
        );
    end

    rr_arb_lock i_rr_arb_lock (
        .clk_i(clk_i), .rst_i(rst_i), .lock_i(lock),
        .valid_i(po_valid), .ready_o(po_ready),
        .data0_i(po_data[0]), .data1_i(po_data[1]), .data2_i(po_data[2]),
        .id0_i(po_id[0]), .id1_i(po_id[1]), .id2_i(po_id[2]),
        .valid_o(arb_valid), .ready_i(arb_ready),
        .data_o(arb_data), .id_o(arb_id), .operation_o(arb_op)
    );

    time_dmr_end #(
        .lock_timeout(lock_timeout)
    ) i_time_dmr_end (
        .clk_i(clk_i), .rst_i(rst_i),
        .operation_i(arb_op), .data_i(arb_data), .id_i(arb_id),
        .valid_i(arb_valid), .ready_o(arb_ready),
        .operation_o(de_op), .data_o(de_data), .id_o(de_id), .faulty_o(de_faulty),
        .valid_o(de_valid), .ready_i(de_ready), .lock_o(lock)
    );

    retry_end i_retry_end (
        .clk_i(clk_i), .rst_i(rst_i),
        .operation_i(de_op), .data_i(de_data), .id_i(de_id), .faulty_i(de_faulty),
        .valid_i(de_valid), .ready_o(de_ready),
        .operation_o(operation_o), .data_o(data_o), .valid_o(valid_o), .ready_i(ready_i),
        .failed_id_o(failed_id), .failed_valid_o(failed_valid), .failed_ready_i(failed_ready)
    );

    // Issued codes, retries included, select an existing pipe
    a_op_in_range: assert property (
        @(posedge clk_i) disable iff (rst_i) ds_valid |-> ds_op < tdr_pkg::num_opgroups
    );

endmodule

`default_nettype wire

// File: hdl/time_dmr_end.sv
`timescale 1ns/10ps
`default_nettype none

module time_dmr_end #(
    parameter int unsigned lock_timeout = 5
) (
    input  logic           clk_i,
    input  logic           rst_i,
    input  tdr_pkg::op_t   operation_i,
    input  tdr_pkg::data_t data_i,
    input  tdr_pkg::id_t   id_i,
    input  logic           valid_i,
    output logic           ready_o,
    output tdr_pkg::op_t   operation_o,
    output tdr_pkg::data_t data_o,
    output tdr_pkg::id_t   id_o,
    output logic           faulty_o,
    output logic           valid_o,
    input  logic           ready_i,
    output logic           lock_o
);

    typedef enum logic {
        st_first,
        st_second
    } state_t;

    localparam int unsigned cnt_width = $clog2(lock_timeout + 1);

    state_t               state_q;
    logic [cnt_width-1:0] cnt_q;
    logic                 timed_out;

    // First copy, kept until its partner shows up
    tdr_pkg::op_t   op_q;
    tdr_pkg::data_t data_q;
    tdr_pkg::id_t   id_q;

    assign timed_out = (state_q == st_second) && (cnt_q == cnt_width'(lock_timeout));

    // Hold the arbiter on this opgroup while the partner is awaited
    assign lock_o = (state_q == st_second) && !timed_out;

    assign operation_o = op_q;
    assign data_o = data_q;
    assign id_o = id_q;

    always_comb begin
        ready_o = 1'b1;
        valid_o = 1'b0;
        faulty_o = 1'b0;
        case (state_q)
            st_first: begin
                // Absorb the first copy silently
                ready_o = 1'b1;
            end
            st_second: begin
                if (timed_out) begin
                    ready_o = 1'b0;
                    valid_o = 1'b1;
                    faulty_o = 1'b1;
                end else begin
                    ready_o = ready_i;
                    valid_o = valid_i;
                    faulty_o = (data_i != data_q) || (id_i != id_q);
                end
            end
            default: begin
                ready_o = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= st_first;
            cnt_q <= '0;
        end else begin
            case (state_q)
                st_first: begin
                    if (valid_i) begin
                        state_q <= st_second;
                        cnt_q <= '0;
                    end
                end
                st_second: begin
                    if (valid_o && ready_i) begin
                        state_q <= st_first;
                    end else if (!valid_i && !timed_out) begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= st_first;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == st_first && valid_i) begin
            op_q <= operation_i;
            data_q <= data_i;
            id_q <= id_i;
        end
    end

    a_cnt_bounded: assert property (
        @(posedge clk_i) disable iff (rst_i) cnt_q <= cnt_width'(lock_timeout)
    );

endmodule

`default_nettype wire

// File: hdl/time_dmr_start.sv
`timescale 1ns/10ps
`default_nettype none

module time_dmr_start (
    input  logic           clk_i,
    input  logic           rst_i,
    input  tdr_pkg::op_t   operation_i,
    input  tdr_pkg::data_t data_i,
    input  tdr_pkg::id_t   id_i,
    input  logic           valid_i,
    output logic           ready_o,
    output tdr_pkg::op_t   operation_o,
    output tdr_pkg::data_t data_o,
    output tdr_pkg::id_t   id_o,
    output logic           valid_o,
    input  logic           ready_i
);

    logic valid_q;
    // Low while copy 0 waits, high for copy 1
    logic copy_q;

    tdr_pkg::op_t   op_q;
    tdr_pkg::data_t data_q;
    tdr_pkg::id_t   id_q;

    // Next item only after both copies are gone
    assign ready_o = ~valid_q;
    assign valid_o = valid_q;
    assign operation_o = op_q;
    assign data_o = data_q;
    assign id_o = id_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            copy_q <= 1'b0;
        end else if (valid_i && ready_o) begin
            valid_q <= 1'b1;
            copy_q <= 1'b0;
        end else if (valid_q && ready_i) begin
            valid_q <= ~copy_q;
            copy_q <= ~copy_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            op_q <= operation_i;
            data_q <= data_i;
            id_q <= id_i;
        end
    end

    a_hold_until_taken: assert property (
        @(posedge clk_i) disable iff (rst_i)
        valid_o && !ready_i |=> valid_o && $stable(data_o) && $stable(id_o)
    );

endmodule

`default_nettype wire
